// File: source/vdecode_pkg.sv
// Covers RVV 1.0 encodings for loads, stores, OPI, OPM and vset only, and vsew code 2'b11 acts as SEW32
package vdecode_pkg;

    // Major opcodes in instr[6:0]
    typedef enum logic [6:0] {
        LOAD    = 7'b0000111,
        STORE   = 7'b0100111,
        ALU_CFG = 7'b1010111
    } vmajor_t;

    // Arithmetic format in funct3
    typedef enum logic [2:0] {
        OPIVV = 3'b000,
        OPFVV = 3'b001,
        OPMVV = 3'b010,
        OPIVI = 3'b011,
        OPIVX = 3'b100,
        OPFVF = 3'b101,
        OPMVX = 3'b110,
        OPCFG = 3'b111
    } vfunct3_t;

    // Load/store addressing mode
    typedef enum logic [1:0] {
        UNIT     = 2'b00,
        UINDEXED = 2'b01,
        STRIDED  = 2'b10,
        OINDEXED = 2'b11
    } mop_t;

    // Memory width field, vector encodings only
    typedef enum logic [2:0] {
        W8  = 3'b000,
        W16 = 3'b101,
        W32 = 3'b110
    } width_t;

    typedef enum logic [1:0] {
        SEW8  = 2'b00,
        SEW16 = 2'b01,
        SEW32 = 2'b10
    } vsew_t;

    typedef enum logic [1:0] {
        NOT_CFG,
        VSETVLI,
        VSETIVLI,
        VSETVL
    } vset_t;

    // Target execution unit
    typedef enum logic [1:0] {
        ALU,
        RED,
        MUL
    } vfu_t;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, MIN, MAX, MACC
    } valuop_t;

    // Load/store view of the word
    typedef struct packed {
        logic [2:0] nf;
        logic       mew;
        mop_t       mop;
        logic       vm;
        logic [4:0] vs2_lumop;
        logic [4:0] rs1;
        width_t     width;
        logic [4:0] vd_vs3;
        logic [6:0] opcode;
    } vmem_fmt_t;

    // Arithmetic and vset view of the word
    typedef struct packed {
        logic [5:0] funct6;
        logic       vm;
        logic [4:0] vs2;
        logic [4:0] vs1_rs1_imm;
        vfunct3_t   funct3;
        logic [4:0] vd;
        logic [6:0] opcode;
    } valu_fmt_t;

    typedef union packed {
        vmem_fmt_t mem;
        valu_fmt_t alu;
    } vinstr_t;

    // Bytes per element
    function automatic logic [2:0] eew_bytes(input vsew_t sew);
        case (sew)
            SEW8:    eew_bytes = 3'd1;
            SEW16:   eew_bytes = 3'd2;
            default: eew_bytes = 3'd4;
        endcase
    endfunction

    // Widening step, stuck at SEW32
    function automatic vsew_t double_sew(input vsew_t sew);
        case (sew)
            SEW8:    double_sew = SEW16;
            default: double_sew = SEW32;
        endcase
    endfunction

endpackage

// File: source/vopi_decode.sv
// Integer OPI subset only, so fixed-point clips, compares and moves decode as invalid
`timescale 1ns/1ps

module vopi_decode (
    input  logic [5:0]             funct6,
    input  vdecode_pkg::vfunct3_t  funct3,
    output vdecode_pkg::vfu_t      vfu,
    output vdecode_pkg::valuop_t   valuop,
    output logic                   vopunsigned,
    output logic                   valid
);
    import vdecode_pkg::*;

    logic hit;
    logic fmt_ok;

    // Every OPI op here runs in the ALU
    assign vfu = ALU;

    // Vector-vector, immediate and scalar forms
    assign fmt_ok = (funct3 == OPIVV) || (funct3 == OPIVI) || (funct3 == OPIVX);

    always_comb begin
        valuop      = ADD;
        vopunsigned = 1'b0;
        hit         = 1'b1;
        case (funct6)
            6'b000000: valuop = ADD;
            6'b000010: valuop = SUB;
            6'b000100: begin
                valuop      = MIN;
                vopunsigned = 1'b1;
            end
            6'b000110: begin
                valuop      = MAX;
                vopunsigned = 1'b1;
            end
            6'b001001: valuop = AND;
            6'b001010: valuop = OR;
            6'b001011: valuop = XOR;
            6'b100101: valuop = SLL;
            // Logical shifts see the operand as unsigned
            6'b101000, 6'b101100: begin
                valuop      = SRL;
                vopunsigned = 1'b1;
            end
            6'b101001, 6'b101101: valuop = SRA;
            default:   hit = 1'b0;
        endcase
    end

    assign valid = hit & fmt_ok;

endmodule

// File: source/vopm_decode.sv
// Two reductions, three multiplies and two widening adds, all other OPM funct6 codes are invalid
`timescale 1ns/1ps

module vopm_decode (
    input  logic [5:0]             funct6,
    input  vdecode_pkg::vfunct3_t  funct3,
    output vdecode_pkg::vfu_t      vfu,
    output vdecode_pkg::valuop_t   valuop,
    output logic                   vopunsigned,
    output logic                   valid
);
    import vdecode_pkg::*;

    logic hit;

    always_comb begin
        vfu         = MUL;
        valuop      = ADD;
        vopunsigned = 1'b0;
        hit         = 1'b1;
        case (funct6)
            // Reductions
            6'b000000: begin
                vfu    = RED;
                valuop = ADD;
            end
            6'b000001: begin
                vfu    = RED;
                valuop = AND;
            end
            // High half of the product as a right shift
            6'b100100: begin
                valuop      = SRL;
                vopunsigned = 1'b1;
            end
            // Low half of the product
            6'b100101: valuop = ADD;
            6'b101101: valuop = MACC;
            // Widening adds use the wide multiplier path
            6'b110000: vopunsigned = 1'b1;
            6'b110001: valuop = ADD;
            default:   hit = 1'b0;
        endcase
    end

    assign valid = hit & ((funct3 == OPMVV) || (funct3 == OPMVX));

endmodule

// File: source/vuop_gen.sv
// One micro-op per vector register, and gen, veew and vl must stay stable while busy is high
`timescale 1ns/1ps

module vuop_gen #(
    parameter int VLEN_BYTES = 16,
    parameter int LANES      = 4,
    parameter int MAX_UOPS   = 8,
    parameter int VL_W       = 8
) (
    input  logic                        CLK,
    input  logic                        arst_n,
    input  logic                        gen,
    input  logic                        stall,
    input  vdecode_pkg::vsew_t          veew,
    input  logic [VL_W-1:0]             vl,
    output logic                        uop_valid,
    output logic                        busy,
    output logic [$clog2(MAX_UOPS)-1:0] uop_num,
    output logic [$clog2(MAX_UOPS)-1:0] reg_offset,
    output logic [LANES-1:0]            lane_active
);
    import vdecode_pkg::*;

    localparam int IDX_W      = $clog2(MAX_UOPS);
    localparam int CNT_W      = IDX_W + 1;
    // Holds vl times four bytes and every byte offset in the group
    localparam int OFF_W      = VL_W + 3;
    localparam int LANE_BYTES = VLEN_BYTES / LANES;

    logic [IDX_W-1:0] idx;
    logic [OFF_W-1:0] total_bytes;
    logic [OFF_W-1:0] n_raw;
    logic [OFF_W-1:0] uop_base;
    logic [CNT_W-1:0] n_uops;
    logic             last;
    logic             advance;

    // Register count, rounded up
    assign total_bytes = OFF_W'(vl) * OFF_W'(eew_bytes(veew));
    assign n_raw = (total_bytes + OFF_W'(VLEN_BYTES - 1)) / OFF_W'(VLEN_BYTES);

    // Clamp to 1..MAX_UOPS
    always_comb begin
        if (n_raw == '0) begin
            n_uops = CNT_W'(1);
        end else if (n_raw > OFF_W'(MAX_UOPS)) begin
            n_uops = CNT_W'(MAX_UOPS);
        end else begin
            n_uops = n_raw[CNT_W-1:0];
        end
    end

    assign last      = ({1'b0, idx} == n_uops - CNT_W'(1));
    // Micro-op 0 shows as soon as gen is up
    assign uop_valid = gen | busy;
    assign advance   = uop_valid & ~stall;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            idx  <= '0;
            busy <= 1'b0;
        end else if (advance) begin
            if (last) begin
                idx  <= '0;
                busy <= 1'b0;
            end else begin
                idx  <= idx + 1'b1;
                busy <= 1'b1;
            end
        end
    end

    assign uop_num    = idx;
    assign reg_offset = idx;

    // Lane is live if its first element index is below vl
    assign uop_base = OFF_W'(idx) * OFF_W'(VLEN_BYTES);

    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            lane_active[k] = ((uop_base + OFF_W'(k * LANE_BYTES)) >> veew) < OFF_W'(vl);
        end
    end

endmodule

// File: source/vdecode_unit.sv
// No v0 masking, no fractional LMUL and no floating point, and instr, vsew, vl are held while busy
`timescale 1ns/1ps

module vdecode_unit #(
    parameter int VLEN_BYTES = 16,
    parameter int LANES      = 4,
    parameter int MAX_UOPS   = 8,
    parameter int VL_W       = 8
) (
    input  logic                        CLK,
    input  logic                        arst_n,
    input  logic                        vvalid,
    input  logic                        stall,
    input  logic [31:0]                 instr,
    input  vdecode_pkg::vsew_t          vsew,
    input  logic [VL_W-1:0]             vl,
    output logic                        uop_valid,
    output logic                        busy,
    output logic                        illegal,
    output vdecode_pkg::vset_t          vset_type,
    output logic                        sregwen,
    output logic                        vregwen,
    output logic                        vmemrden,
    output logic                        vmemwren,
    output logic                        unitstride,
    output logic                        strided,
    output logic                        indexed,
    output logic                        vxin1_use_imm,
    output logic                        vxin1_use_rs1,
    output logic                        vxin2_use_rs2,
    output logic [4:0]                  vd_idx,
    output logic [4:0]                  vs1_idx,
    output logic [4:0]                  vs2_idx,
    output vdecode_pkg::vsew_t          veew_src1,
    output vdecode_pkg::vsew_t          veew_src2,
    output vdecode_pkg::vsew_t          veew_dest,
    output vdecode_pkg::vfu_t           vfu,
    output vdecode_pkg::valuop_t        valuop,
    output logic                        vopunsigned,
    output logic [$clog2(MAX_UOPS)-1:0] uop_num,
    output logic [LANES-1:0]            lane_active
);
    import vdecode_pkg::*;

    vinstr_t ins;
    logic is_store, is_alu, is_mem, is_cfg;
    vsew_t mem_eew;
    logic widening, narrowing;
    vfu_t opi_vfu, opm_vfu;
    valuop_t opi_op, opm_op;
    logic opi_uns, opm_uns, opi_valid, opm_valid, exec_valid;
    logic [$clog2(MAX_UOPS)-1:0] reg_offset;

    assign ins = instr;

    // Major opcode
    assign vmemrden = (ins.mem.opcode == LOAD);
    assign is_store = (ins.mem.opcode == STORE);
    assign is_alu   = (ins.alu.opcode == ALU_CFG);
    assign vmemwren = is_store;
    assign is_mem   = vmemrden | is_store;
    assign is_cfg   = is_alu && (ins.alu.funct3 == OPCFG);

    // vset kind from bits 31..30
    always_comb begin
        case (ins.alu.funct6[5:4])
            2'b11:   vset_type = VSETIVLI;
            2'b10:   vset_type = VSETVL;
            default: vset_type = VSETVLI;
        endcase
        if (!is_cfg) begin
            vset_type = NOT_CFG;
        end
    end

    // vset* and the scalar move group write x registers
    assign sregwen = is_cfg ||
                     (is_alu && ins.alu.funct3 == OPMVV && ins.alu.funct6 == 6'b010000);
    assign vregwen = !sregwen && !is_store;

    // Addressing mode, memory ops only
    assign unitstride = is_mem && (ins.mem.mop == UNIT);
    assign strided    = is_mem && (ins.mem.mop == STRIDED);
    assign indexed    = is_mem && (ins.mem.mop == UINDEXED || ins.mem.mop == OINDEXED);

    // Operand sources
    assign vxin1_use_imm = is_alu && (ins.alu.funct3 == OPIVI);
    assign vxin1_use_rs1 = is_mem || (is_alu && (ins.alu.funct3 == OPIVX ||
                           ins.alu.funct3 == OPFVF || ins.alu.funct3 == OPMVX));
    // Stride comes from scalar rs2
    assign vxin2_use_rs2 = strided;

    // Group register offset wraps at 32
    assign vd_idx  = ins.alu.vd + {2'b00, reg_offset};
    assign vs1_idx = (is_store ? ins.mem.vd_vs3 : ins.alu.vs1_rs1_imm) + {2'b00, reg_offset};
    assign vs2_idx = ins.alu.vs2 + {2'b00, reg_offset};

    always_comb begin
        case (ins.mem.width)
            W8:      mem_eew = SEW8;
            W16:     mem_eew = SEW16;
            default: mem_eew = SEW32;
        endcase
    end

    // Widening when funct6 starts 11, narrowing shifts vnsrl and vnsra
    assign widening  = is_alu && (ins.alu.funct6[5:4] == 2'b11);
    assign narrowing = is_alu && opi_valid && (ins.alu.funct6[5:1] == 5'b10110);

    assign veew_src1 = vsew;
    assign veew_src2 = indexed ? mem_eew : (narrowing ? double_sew(vsew) : vsew);
    assign veew_dest = is_mem ? mem_eew : (widening ? double_sew(vsew) : vsew);

    vopi_decode u_vopi_decode (
        .funct6      (ins.alu.funct6),
        .funct3      (ins.alu.funct3),
        .vfu         (opi_vfu),
        .valuop      (opi_op),
        .vopunsigned (opi_uns),
        .valid       (opi_valid)
    );

    vopm_decode u_vopm_decode (
        .funct6      (ins.alu.funct6),
        .funct3      (ins.alu.funct3),
        .vfu         (opm_vfu),
        .valuop      (opm_op),
        .vopunsigned (opm_uns),
        .valid       (opm_valid)
    );

    // Sub-decoders only count for arithmetic opcodes
    always_comb begin
        vfu         = ALU;
        valuop      = ADD;
        vopunsigned = 1'b0;
        exec_valid  = 1'b1;
        case ({is_alu & opi_valid, is_alu & opm_valid, is_mem})
            3'b100: begin
                vfu         = opi_vfu;
                valuop      = opi_op;
                vopunsigned = opi_uns;
            end
            3'b010: begin
                vfu         = opm_vfu;
                valuop      = opm_op;
                vopunsigned = opm_uns;
            end
            // Address add for loads and stores
            3'b001:  vopunsigned = 1'b1;
            default: exec_valid = 1'b0;
        endcase
    end

    // vset* needs no execution control
    assign illegal = !(is_mem || is_alu) || (!exec_valid && !is_cfg);

    vuop_gen #(
        .VLEN_BYTES (VLEN_BYTES),
        .LANES      (LANES),
        .MAX_UOPS   (MAX_UOPS),
        .VL_W       (VL_W)
    ) u_vuop_gen (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .gen         (vvalid),
        .stall       (stall),
        .veew        (veew_dest),
        .vl          (vl),
        .uop_valid   (uop_valid),
        .busy        (busy),
        .uop_num     (uop_num),
        .reg_offset  (reg_offset),
        .lane_active (lane_active)
    );

endmodule

// File: dv/tb_clock_gen.sv
// Free-running 10 ns clock, and reset is held low for 8 cycles then released on a falling edge
`timescale 1ns/1ps

module tb_clock_gen (
    output logic CLK,
    output logic arst_n
);
    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    initial begin
        arst_n = 1'b0;
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        arst_n = 1'b1;
    end

endmodule

// File: dv/vdecode_checker.sv
// Expects start_test before the instruction is raised and finish_test once busy has fallen
`timescale 1ns/1ps

module vdecode_checker (
    input logic CLK, arst_n, stall, uop_valid, busy, illegal,
    input vdecode_pkg::vset_t vset_type,
    input logic sregwen, vregwen, vmemrden, vmemwren, unitstride, strided, indexed,
    input logic vxin1_use_imm, vxin1_use_rs1, vxin2_use_rs2,
    input logic [4:0] vd_idx, vs1_idx, vs2_idx,
    input vdecode_pkg::vsew_t veew_src1, veew_src2, veew_dest,
    input vdecode_pkg::vfu_t vfu,
    input vdecode_pkg::valuop_t valuop,
    input logic vopunsigned,
    input logic [2:0] uop_num,
    input logic [3:0] lane_active
);
    import vdecode_pkg::*;

    int errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int test_errors;
    bit active = 0;
    int n_exp;
    int seen[8];
    logic [31:0] e_instr;
    logic [7:0] e_vl;
    logic [9:0] e_flags;
    logic e_illegal, e_uns;
    vset_t e_vset;
    vfu_t e_vfu;
    valuop_t e_op;
    vsew_t e_sew, e_src2, e_dest;

    // Compare one field and report in hex
    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    function automatic int sew_bytes(input vsew_t s);
        return (s == SEW8) ? 1 : ((s == SEW16) ? 2 : 4);
    endfunction

    task automatic start_test(input logic [31:0] instr, input vsew_t sew, input logic [7:0] vl,
                              input logic ill, input vset_t vs, input logic [9:0] flags,
                              input vfu_t fu, input valuop_t op, input logic uns,
                              input vsew_t src2, input vsew_t dest);
        int bytes;
        e_instr = instr;
        e_sew = sew;
        e_vl = vl;
        e_illegal = ill;
        e_vset = vs;
        e_flags = flags;
        e_vfu = fu;
        e_op = op;
        e_uns = uns;
        e_src2 = src2;
        e_dest = dest;
        // Ceiling of the group bytes over 16 clamped to 1..8
        bytes = int'(vl) * sew_bytes(dest);
        n_exp = (bytes + 15) / 16;
        if (n_exp < 1) n_exp = 1;
        if (n_exp > 8) n_exp = 8;
        foreach (seen[i]) seen[i] = 0;
        test_errors = 0;
        active = 1;
    endtask

    task automatic check_uop();
        int i;
        logic [3:0] lanes;
        logic [4:0] src1_field;
        i = int'(uop_num);
        if (i >= n_exp) begin
            $display("Micro-op number %0d is beyond the expected count %0d", i, n_exp);
            test_errors++;
        end else begin
            seen[i]++;
        end
        // Lane k is live when its first element is below vl
        for (int k = 0; k < 4; k++) begin
            lanes[k] = ((i * 16 + 4 * k) / sew_bytes(e_dest)) < int'(e_vl);
        end
        src1_field = e_flags[8] ? e_instr[11:7] : e_instr[19:15];
        // Only micro-op 0 is presented before busy rises
        check_val("busy", busy, i != 0);
        check_val("illegal", illegal, e_illegal);
        check_val("vset_type", vset_type, e_vset);
        check_val("vmemrden", vmemrden, e_flags[9]);
        check_val("vmemwren", vmemwren, e_flags[8]);
        check_val("unitstride", unitstride, e_flags[7]);
        check_val("strided", strided, e_flags[6]);
        check_val("indexed", indexed, e_flags[5]);
        check_val("sregwen", sregwen, e_flags[4]);
        check_val("vregwen", vregwen, e_flags[3]);
        check_val("vxin1_use_imm", vxin1_use_imm, e_flags[2]);
        check_val("vxin1_use_rs1", vxin1_use_rs1, e_flags[1]);
        check_val("vxin2_use_rs2", vxin2_use_rs2, e_flags[0]);
        check_val("veew_src1", veew_src1, e_sew);
        check_val("veew_src2", veew_src2, e_src2);
        check_val("veew_dest", veew_dest, e_dest);
        check_val("vd_idx", vd_idx, 5'(e_instr[11:7] + i));
        check_val("vs1_idx", vs1_idx, 5'(src1_field + i));
        check_val("vs2_idx", vs2_idx, 5'(e_instr[24:20] + i));
        check_val("lane_active", lane_active, lanes);
        // Execution control only matters for legal non-vset words
        if (!e_illegal && e_vset == NOT_CFG) begin
            check_val("vfu", vfu, e_vfu);
            check_val("valuop", valuop, e_op);
            check_val("vopunsigned", vopunsigned, e_uns);
        end
    endtask

    always @(posedge CLK) begin
        if (arst_n && uop_valid && !stall) begin
            if (active) begin
                check_uop();
            end else begin
                $display("Micro-op presented while no instruction was pending");
                errors++;
            end
        end
    end

    task automatic finish_test(input int id);
        for (int i = 0; i < n_exp; i++) begin
            if (seen[i] != 1) begin
                $display("Micro-op %0d was seen %0d times instead of once", i, seen[i]);
                test_errors++;
            end
        end
        active = 0;
        errors += test_errors;
        if (test_errors == 0) tests_passed++;
        else tests_failed++;
        $display("test %0d instr %h: %s, %0d micro-ops, %0d errors", id, e_instr,
                 (test_errors == 0) ? "PASS" : "FAIL", n_exp, test_errors);
    endtask

    task automatic report_counts();
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
    endtask

endmodule

// File: dv/vdecode_asserts.sv
// Assumes the default geometry with a 3-bit micro-op index
`timescale 1ns/1ps

module vdecode_asserts (
    input logic       CLK,
    input logic       arst_n,
    input logic       stall,
    input logic       busy,
    input logic       uop_valid,
    input logic [2:0] uop_num
);
    // No sequence may run while reset is held
    busy_in_reset: assert property (@(posedge CLK) !arst_n |-> !busy)
        else $error("busy high while reset is asserted");

    // A stalled micro-op keeps its number
    index_hold: assert property (@(posedge CLK) disable iff (!arst_n)
        (uop_valid && stall) |=> $stable(uop_num))
        else $error("micro-op index moved under stall");

    valid_when_busy: assert property (@(posedge CLK) disable iff (!arst_n)
        busy |-> uop_valid)
        else $error("busy high without uop_valid");

endmodule

bind vdecode_unit vdecode_asserts u_asserts (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .stall     (stall),
    .busy      (busy),
    .uop_valid (uop_valid),
    .uop_num   (uop_num)
);

// File: dv/vdecode_tb.sv
// Rows run one at a time with random stall, and every wait gives up after 64 cycles
`timescale 1ns/1ps

module vdecode_tb;
    import vdecode_pkg::*;

    typedef struct {
        logic [31:0] instr;
        vsew_t       sew;
        logic [7:0]  vl;
        int          stall_pct;
        logic        ill;
        vset_t       vs;
        logic [9:0]  flags;
        vfu_t        fu;
        valuop_t     op;
        logic        uns;
        vsew_t       src2;
        vsew_t       dest;
    } row_t;

    logic CLK, arst_n, vvalid, stall, uop_valid, busy, illegal;
    logic [31:0] instr;
    vsew_t vsew, veew_src1, veew_src2, veew_dest;
    logic [7:0] vl;
    vset_t vset_type;
    logic sregwen, vregwen, vmemrden, vmemwren, unitstride, strided, indexed;
    logic vxin1_use_imm, vxin1_use_rs1, vxin2_use_rs2, vopunsigned;
    logic [4:0] vd_idx, vs1_idx, vs2_idx;
    vfu_t vfu;
    valuop_t valuop;
    logic [2:0] uop_num;
    logic [3:0] lane_active;
    row_t rows[$];
    bit hung = 0;

    tb_clock_gen u_clk (.CLK(CLK), .arst_n(arst_n));
    vdecode_unit uut (.*);
    vdecode_checker chk (.*);

    // Fixed register fields, vs3 is 6 so store sources differ from vs1
    function automatic logic [31:0] enc_mem(input vmajor_t opc, input mop_t mop, input width_t w);
        return {3'b000, 1'b0, mop, 1'b1, 5'd8, 5'd10, w, 5'd6, opc};
    endfunction

    // vd of 30 makes the group wrap past register 31
    function automatic logic [31:0] enc_alu(input logic [5:0] f6, input vfunct3_t f3);
        return {f6, 1'b1, 5'd8, 5'd5, f3, 5'd30, ALU_CFG};
    endfunction

    task automatic add(input logic [31:0] i, input vsew_t s, input logic [7:0] l, input int p,
                       input logic ill, input vset_t vs, input logic [9:0] f, input vfu_t fu,
                       input valuop_t op, input logic u, input vsew_t s2, input vsew_t d);
        rows.push_back('{i, s, l, p, ill, vs, f, fu, op, u, s2, d});
    endtask

    function automatic logic pick_stall(input int pct);
        return ($urandom % 100) < pct;
    endfunction

    task automatic run_row(input int id);
        row_t r;
        bit accepted;
        int c;
        r = rows[id];
        chk.start_test(r.instr, r.sew, r.vl, r.ill, r.vs, r.flags, r.fu, r.op, r.uns,
                       r.src2, r.dest);
        instr  = r.instr;
        vsew   = r.sew;
        vl     = r.vl;
        vvalid = 1'b1;
        accepted = 0;
        // Accepted at the next rising edge when stall is low
        for (c = 0; c < 64 && !accepted; c++) begin
            stall = pick_stall(r.stall_pct);
            accepted = !stall;
            @(negedge CLK);
        end
        vvalid = 1'b0;
        for (c = 0; c < 64 && busy; c++) begin
            stall = pick_stall(r.stall_pct);
            @(negedge CLK);
        end
        stall = 1'b0;
        if (!accepted || busy) begin
            $display("Row %0d timed out waiting for the decoder to finish", id);
            hung = 1;
        end else begin
            chk.finish_test(id);
        end
    endtask

    initial begin
        int c;
        vvalid = 1'b0;
        stall  = 1'b0;
        instr  = 32'h0;
        vsew   = SEW8;
        vl     = 8'd0;
        void'($urandom(32'h9784b1e0));

        // Memory modes and widths
        add(enc_mem(LOAD, UNIT, W8), SEW8, 20, 25, 0, NOT_CFG, 10'b1010001010, ALU, ADD, 1, SEW8, SEW8);
        add(enc_mem(LOAD, STRIDED, W16), SEW8, 10, 25, 0, NOT_CFG, 10'b1001001011, ALU, ADD, 1, SEW8, SEW16);
        add(enc_mem(LOAD, UINDEXED, W32), SEW8, 5, 50, 0, NOT_CFG, 10'b1000101010, ALU, ADD, 1, SEW32, SEW32);
        add(enc_mem(STORE, UNIT, W32), SEW32, 9, 25, 0, NOT_CFG, 10'b0110000010, ALU, ADD, 1, SEW32, SEW32);
        add(enc_mem(STORE, OINDEXED, W16), SEW16, 0, 0, 0, NOT_CFG, 10'b0100100010, ALU, ADD, 1, SEW16, SEW16);
        add(enc_mem(STORE, STRIDED, W8), SEW8, 64, 50, 0, NOT_CFG, 10'b0101000011, ALU, ADD, 1, SEW8, SEW8);
        // OPI table
        add(enc_alu(6'b000000, OPIVV), SEW32, 32, 25, 0, NOT_CFG, 10'b0000001000, ALU, ADD, 0, SEW32, SEW32);
        add(enc_alu(6'b000000, OPIVV), SEW32, 200, 50, 0, NOT_CFG, 10'b0000001000, ALU, ADD, 0, SEW32, SEW32);
        add(enc_alu(6'b000010, OPIVX), SEW16, 13, 25, 0, NOT_CFG, 10'b0000001010, ALU, SUB, 0, SEW16, SEW16);
        add(enc_alu(6'b000100, OPIVI), SEW8, 7, 25, 0, NOT_CFG, 10'b0000001100, ALU, MIN, 1, SEW8, SEW8);
        add(enc_alu(6'b000110, OPIVV), SEW8, 3, 25, 0, NOT_CFG, 10'b0000001000, ALU, MAX, 1, SEW8, SEW8);
        add(enc_alu(6'b001001, OPIVV), SEW16, 9, 25, 0, NOT_CFG, 10'b0000001000, ALU, AND, 0, SEW16, SEW16);
        add(enc_alu(6'b001010, OPIVX), SEW32, 6, 25, 0, NOT_CFG, 10'b0000001010, ALU, OR, 0, SEW32, SEW32);
        add(enc_alu(6'b001011, OPIVI), SEW32, 4, 25, 0, NOT_CFG, 10'b0000001100, ALU, XOR, 0, SEW32, SEW32);
        add(enc_alu(6'b100101, OPIVV), SEW8, 40, 25, 0, NOT_CFG, 10'b0000001000, ALU, SLL, 0, SEW8, SEW8);
        add(enc_alu(6'b101000, OPIVV), SEW16, 17, 25, 0, NOT_CFG, 10'b0000001000, ALU, SRL, 1, SEW16, SEW16);
        add(enc_alu(6'b101001, OPIVX), SEW16, 2, 25, 0, NOT_CFG, 10'b0000001010, ALU, SRA, 0, SEW16, SEW16);
        add(enc_alu(6'b101100, OPIVV), SEW8, 24, 25, 0, NOT_CFG, 10'b0000001000, ALU, SRL, 1, SEW16, SEW8);
        add(enc_alu(6'b101101, OPIVI), SEW32, 8, 25, 0, NOT_CFG, 10'b0000001100, ALU, SRA, 0, SEW32, SEW32);
        // OPM table, widening saturates at SEW32
        add(enc_alu(6'b000000, OPMVV), SEW32, 16, 25, 0, NOT_CFG, 10'b0000001000, RED, ADD, 0, SEW32, SEW32);
        add(enc_alu(6'b000001, OPMVV), SEW8, 16, 25, 0, NOT_CFG, 10'b0000001000, RED, AND, 0, SEW8, SEW8);
        add(enc_alu(6'b100100, OPMVX), SEW16, 12, 25, 0, NOT_CFG, 10'b0000001010, MUL, SRL, 1, SEW16, SEW16);
        add(enc_alu(6'b100101, OPMVV), SEW32, 11, 25, 0, NOT_CFG, 10'b0000001000, MUL, ADD, 0, SEW32, SEW32);
        add(enc_alu(6'b101101, OPMVX), SEW8, 33, 25, 0, NOT_CFG, 10'b0000001010, MUL, MACC, 0, SEW8, SEW8);
        add(enc_alu(6'b110000, OPMVV), SEW16, 10, 25, 0, NOT_CFG, 10'b0000001000, MUL, ADD, 1, SEW16, SEW32);
        add(enc_alu(6'b110001, OPMVX), SEW32, 5, 25, 0, NOT_CFG, 10'b0000001010, MUL, ADD, 0, SEW32, SEW32);
        // vset kinds and the scalar move
        add(enc_alu(6'b000000, OPCFG), SEW8, 1, 0, 0, VSETVLI, 10'b0000010000, ALU, ADD, 0, SEW8, SEW8);
        add(enc_alu(6'b110000, OPCFG), SEW32, 1, 0, 0, VSETIVLI, 10'b0000010000, ALU, ADD, 0, SEW32, SEW32);
        add(enc_alu(6'b100000, OPCFG), SEW16, 1, 0, 0, VSETVL, 10'b0000010000, ALU, ADD, 0, SEW16, SEW16);
        add(enc_alu(6'b010000, OPMVV), SEW8, 1, 0, 1, NOT_CFG, 10'b0000010000, ALU, ADD, 0, SEW8, SEW8);
        // Illegal words
        add(enc_alu(6'b000000, OPFVV), SEW32, 4, 25, 1, NOT_CFG, 10'b0000001000, ALU, ADD, 0, SEW32, SEW32);
        add(enc_alu(6'b000000, OPFVF), SEW32, 4, 25, 1, NOT_CFG, 10'b0000001010, ALU, ADD, 0, SEW32, SEW32);
        add(enc_alu(6'b000001, OPIVV), SEW8, 4, 25, 1, NOT_CFG, 10'b0000001000, ALU, ADD, 0, SEW8, SEW8);
        add(32'h0000_007f, SEW8, 4, 25, 1, NOT_CFG, 10'b0000001000, ALU, ADD, 0, SEW8, SEW8);

        for (c = 0; c < 64 && !arst_n; c++) begin
            @(negedge CLK);
        end
        if (!arst_n) begin
            $display("Reset was never released");
            hung = 1;
        end
        @(negedge CLK);
        foreach (rows[i]) begin
            if (!hung) run_row(i);
        end
        chk.report_counts();
        if (hung || chk.errors != 0 || chk.tests_failed != 0) begin
            $display("Test failures found");
        end else begin
            $display("All tests passed!");
        end
        $finish;
    end

endmodule

// File: sources.f
source/vdecode_pkg.sv
source/vopi_decode.sv
source/vopm_decode.sv
source/vuop_gen.sv
source/vdecode_unit.sv
dv/tb_clock_gen.sv
dv/vdecode_checker.sv
dv/vdecode_asserts.sv
dv/vdecode_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= vdecode_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "All tests passed!" $(LOG) || (echo "Simulation ended early"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
